//--- project.f
logic/decodePkg.sv
logic/fieldDecoder.sv
logic/controlDecoder.sv
logic/aluControlDecoder.sv
logic/creditQueue.sv
logic/decodeStage.sv
tests/decodeStage_checker.sv
tests/decodeStageMonitor.sv
tests/decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module decodeStageTb \
    -Mdir obj_dir -o decodeStageSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/decodeStageSim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- tests/decodeStageTb.sv
// Testbench with clock, reset, stimulus table, credit models, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

bind creditQueue decodeStage_checker #(
    .Depth       (Depth),
    .CountWidth  (CountWidth),
    .CreditWidth (CreditWidth)
) checker_inst (
    .clk         (clk),
    .rst         (rst),
    .outValid    (outValid),
    .inCredit    (inCredit),
    .occupancy   (occupancy),
    .creditCount (creditCount)
);

module decodeStageTb import decodePkg::*; ;

    localparam int QueueDepth = 4;
    localparam int OutCredits = 2;
    localparam int NumRows    = 33;

    logic            clk;
    logic            rst;
    logic            inValid;
    logic [31:0]     instruction;
    logic            outCredit;
    logic            inCredit;
    logic            outValid;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      func3;
    logic [31:0]     imm;
    logic            memWrite;
    logic            memRead;
    logic            regWrite;
    logic            aluSrc;
    logic            branch;
    logic            memToReg;
    aluOp_t          aluOp;
    aluCtrl_t        aluControl;

    logic            pushValid;
    logic [63:0]     pushExp;
    int              passCount;
    int              failCount;
    int              checkedCount;

    logic [31:0]     instrTable [NumRows];
    logic [63:0]     expTable [NumRows];
    int              rowCount;
    int              upCredits;
    int              otherErrors;
    int              rowIdx;
    int              downHeld;
    int              heldNext;
    integer          seed;

    decodeStage #(
        .QueueDepth (QueueDepth),
        .OutCredits (OutCredits)
    ) decodeStage_inst (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .instruction (instruction),
        .inCredit    (inCredit),
        .outValid    (outValid),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .func3       (func3),
        .imm         (imm),
        .memWrite    (memWrite),
        .memRead     (memRead),
        .regWrite    (regWrite),
        .aluSrc      (aluSrc),
        .branch      (branch),
        .memToReg    (memToReg),
        .aluOp       (aluOp),
        .aluControl  (aluControl),
        .outCredit   (outCredit)
    );

    decodeStageMonitor monitor_inst (
        .clk          (clk),
        .rst          (rst),
        .pushValid    (pushValid),
        .pushExp      (pushExp),
        .outValid     (outValid),
        .rd           (rd),
        .rs1          (rs1),
        .rs2          (rs2),
        .func3        (func3),
        .imm          (imm),
        .flags        ({memWrite, memRead, regWrite, aluSrc, branch, memToReg}),
        .aluOp        (aluOp),
        .aluControl   (aluControl),
        .passCount    (passCount),
        .failCount    (failCount),
        .checkedCount (checkedCount)
    );

    always #20 clk = ~clk;

    // Flags are memWrite memRead regWrite aluSrc branch memToReg
    task automatic addRow(input logic [31:0] word, input logic [4:0] eRd,
                          input logic [4:0] eRs1, input logic [4:0] eRs2,
                          input logic [2:0] eF3, input logic [31:0] eImm,
                          input logic [5:0] eFlags, input aluOp_t eOp,
                          input aluCtrl_t eCtrl);
        instrTable[rowCount] = word;
        expTable[rowCount] = {eRd, eRs1, eRs2, eF3, eImm, eFlags, eOp, eCtrl};
        rowCount = rowCount + 1;
    endtask

    task automatic loadTable();
        // Upper immediates and jumps
        addRow(32'h123452B7, 5, 8, 3, 5, 32'h12345000, 6'b001100, AluOpUpper, AluAdd);
        addRow(32'hFFFFF097, 1, 31, 31, 7, 32'hFFFFF000, 6'b001100, AluOpPc, AluAdd);
        addRow(32'hFFDFF0EF, 1, 31, 29, 7, 32'hFFFFFFFC, 6'b001110, AluOpJump, AluAdd);
        addRow(32'h00808067, 0, 1, 8, 0, 32'h00000008, 6'b001110, AluOpJumpReg, AluAdd);
        // Load, store, branches
        addRow(32'hFF81A103, 2, 3, 24, 2, 32'hFFFFFFF8, 6'b011101, AluOpMem, AluAdd);
        addRow(32'hFE532E23, 28, 6, 5, 2, 32'hFFFFFFFC, 6'b100100, AluOpMem, AluAdd);
        addRow(32'hFE208CE3, 25, 1, 2, 0, 32'hFFFFFFF8, 6'b000010, AluOpBranch, AluSub);
        addRow(32'h00419863, 16, 3, 4, 1, 32'h00000010, 6'b000010, AluOpBranch, AluSub);
        // OpImm with all func3 values plus SRAI
        addRow(32'hFFF10093, 1, 2, 31, 0, 32'hFFFFFFFF, 6'b001100, AluOpArith, AluAdd);
        addRow(32'h00311093, 1, 2, 3, 1, 32'h00000003, 6'b001100, AluOpArith, AluSll);
        addRow(32'h00512093, 1, 2, 5, 2, 32'h00000005, 6'b001100, AluOpArith, AluSlt);
        addRow(32'h00713093, 1, 2, 7, 3, 32'h00000007, 6'b001100, AluOpArith, AluSltu);
        addRow(32'h0FF14093, 1, 2, 31, 4, 32'h000000FF, 6'b001100, AluOpArith, AluXor);
        addRow(32'h00415093, 1, 2, 4, 5, 32'h00000004, 6'b001100, AluOpArith, AluSrl);
        addRow(32'h40415093, 1, 2, 4, 5, 32'h00000404, 6'b001100, AluOpArith, AluSra);
        addRow(32'hFF016093, 1, 2, 16, 6, 32'hFFFFFFF0, 6'b001100, AluOpArith, AluOr);
        addRow(32'h7FF17093, 1, 2, 31, 7, 32'h000007FF, 6'b001100, AluOpArith, AluAnd);
        // OpReg base words
        addRow(32'h005201B3, 3, 4, 5, 0, 32'h0, 6'b001000, AluOpArith, AluAdd);
        addRow(32'h405201B3, 3, 4, 5, 0, 32'h0, 6'b001000, AluOpArith, AluSub);
        addRow(32'h005251B3, 3, 4, 5, 5, 32'h0, 6'b001000, AluOpArith, AluSrl);
        addRow(32'h405251B3, 3, 4, 5, 5, 32'h0, 6'b001000, AluOpArith, AluSra);
        addRow(32'h005221B3, 3, 4, 5, 2, 32'h0, 6'b001000, AluOpArith, AluSlt);
        // M extension
        addRow(32'h025201B3, 3, 4, 5, 0, 32'h0, 6'b001000, AluOpArith, AluMul);
        addRow(32'h025211B3, 3, 4, 5, 1, 32'h0, 6'b001000, AluOpArith, AluMulh);
        addRow(32'h025221B3, 3, 4, 5, 2, 32'h0, 6'b001000, AluOpArith, AluMulhsu);
        addRow(32'h025231B3, 3, 4, 5, 3, 32'h0, 6'b001000, AluOpArith, AluMulhu);
        addRow(32'h025241B3, 3, 4, 5, 4, 32'h0, 6'b001000, AluOpArith, AluDiv);
        addRow(32'h025251B3, 3, 4, 5, 5, 32'h0, 6'b001000, AluOpArith, AluDivu);
        addRow(32'h025261B3, 3, 4, 5, 6, 32'h0, 6'b001000, AluOpArith, AluRem);
        addRow(32'h025271B3, 3, 4, 5, 7, 32'h0, 6'b001000, AluOpArith, AluRemu);
        // NOP fallbacks for ECALL, unknown opcode and low bits 00
        addRow(32'h00000073, 0, 0, 0, 0, 32'h0, 6'b000100, AluOpArith, AluAdd);
        addRow(32'h00C3D2FF, 5, 7, 12, 5, 32'h0, 6'b000100, AluOpArith, AluAdd);
        addRow(32'h12345234, 4, 8, 3, 5, 32'h0, 6'b000100, AluOpArith, AluAdd);
    endtask

    // Downstream holds issued entries and frees them at random
    always @(posedge clk)
    begin
        if (rst)
        begin
            outCredit <= 1'b0;
            downHeld = 0;
        end
        else
        begin
            heldNext = downHeld + (outValid ? 1 : 0);
            if (heldNext > OutCredits)
            begin
                $display("Error: downstream received more entries than credits at %0t ns",
                         $time);
                otherErrors = otherErrors + 1;
            end
            if ((heldNext != 0) && (($random(seed) & 3) == 0))
            begin
                outCredit <= 1'b1;
                heldNext = heldNext - 1;
            end
            else
            begin
                outCredit <= 1'b0;
            end
            downHeld = heldNext;
        end
    end

    // Watchdog sized from the table length
    initial
    begin
        #((NumRows * 20 + 10) * 40);
        $display("Run timed out before all table rows were issued");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        seed = 16;
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        instruction = '0;
        outCredit = 1'b0;
        pushValid = 1'b0;
        pushExp = '0;
        rowCount = 0;
        otherErrors = 0;
        downHeld = 0;
        upCredits = QueueDepth;
        loadTable();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Send a row only while an upstream credit is held
        rowIdx = 0;
        while (rowIdx < NumRows)
        begin
            @(posedge clk);
            if (inCredit)
            begin
                upCredits = upCredits + 1;
            end
            if (upCredits > QueueDepth)
            begin
                $display("Error: upstream credits exceeded queue depth at %0t ns", $time);
                otherErrors = otherErrors + 1;
            end
            if (upCredits > 0)
            begin
                inValid <= 1'b1;
                instruction <= instrTable[rowIdx];
                pushValid <= 1'b1;
                pushExp <= expTable[rowIdx];
                upCredits = upCredits - 1;
                rowIdx = rowIdx + 1;
            end
            else
            begin
                inValid <= 1'b0;
                pushValid <= 1'b0;
            end
        end
        @(posedge clk);
        if (inCredit)
        begin
            upCredits = upCredits + 1;
        end
        inValid <= 1'b0;
        pushValid <= 1'b0;

        // Drain while collecting the remaining credits
        while ((passCount + failCount) < NumRows)
        begin
            @(posedge clk);
            if (inCredit)
            begin
                upCredits = upCredits + 1;
            end
        end
        repeat (2) @(posedge clk);
        if (upCredits != QueueDepth)
        begin
            $display("Error: %0d upstream credits held at end, %0d expected",
                     upCredits, QueueDepth);
            otherErrors = otherErrors + 1;
        end

        $display("Tests: %0d passed, %0d failed, %0d other errors",
                 passCount, failCount, otherErrors);
        if ((failCount == 0) && (otherErrors == 0) && (passCount == NumRows))
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/decodeStageMonitor.sv
// Expected-row queue and field-by-field comparison of every issued decode entry
`timescale 1ns/1ps
`default_nettype none

module decodeStageMonitor (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        pushValid,
    input wire logic [63:0] pushExp,
    input wire logic        outValid,
    input wire logic [4:0]  rd,
    input wire logic [4:0]  rs1,
    input wire logic [4:0]  rs2,
    input wire logic [2:0]  func3,
    input wire logic [31:0] imm,
    input wire logic [5:0]  flags,
    input wire logic [2:0]  aluOp,
    input wire logic [4:0]  aluControl,
    output int              passCount,
    output int              failCount,
    output int              checkedCount
);

    logic [63:0] expQ[$];
    logic [63:0] expRow;
    logic [63:0] gotRow;
    bit          rowOk;

    // Report one field mismatch
    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %0t ns: test %0d field %s got 0x%0h expected 0x%0h",
                     $time, checkedCount, name, got, exp);
            rowOk = 1'b0;
        end
    endtask

    initial
    begin
        passCount = 0;
        failCount = 0;
        checkedCount = 0;
    end

    always @(posedge clk)
    begin
        // Expected rows kept in drive order
        if (pushValid)
        begin
            expQ.push_back(pushExp);
        end
        if (!rst && outValid)
        begin
            if (expQ.size() == 0)
            begin
                $display("Error: output issued with no pending expected row at %0t ns", $time);
                failCount = failCount + 1;
            end
            else
            begin
                expRow = expQ.pop_front();
                gotRow = {rd, rs1, rs2, func3, imm, flags, aluOp, aluControl};
                rowOk = 1'b1;
                compareField("rd", 32'(gotRow[63:59]), 32'(expRow[63:59]));
                compareField("rs1", 32'(gotRow[58:54]), 32'(expRow[58:54]));
                compareField("rs2", 32'(gotRow[53:49]), 32'(expRow[53:49]));
                compareField("func3", 32'(gotRow[48:46]), 32'(expRow[48:46]));
                compareField("imm", gotRow[45:14], expRow[45:14]);
                // Flag order memWrite memRead regWrite aluSrc branch memToReg
                compareField("flags", 32'(gotRow[13:8]), 32'(expRow[13:8]));
                compareField("aluOp", 32'(gotRow[7:5]), 32'(expRow[7:5]));
                compareField("aluControl", 32'(gotRow[4:0]), 32'(expRow[4:0]));
                if (rowOk)
                begin
                    $display("PASS test %0d at %0t ns", checkedCount, $time);
                    passCount = passCount + 1;
                end
                else
                begin
                    failCount = failCount + 1;
                end
                checkedCount = checkedCount + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/decodeStage_checker.sv
// Concurrent assertions on queue credits, occupancy and reset state of the credit queue
`timescale 1ns/1ps
`default_nettype none

module decodeStage_checker #(
    parameter int Depth       = 4,
    parameter int CountWidth  = 3,
    parameter int CreditWidth = 2
) (
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic                   outValid,
    input wire logic                   inCredit,
    input wire logic [CountWidth-1:0]  occupancy,
    input wire logic [CreditWidth-1:0] creditCount
);

    // Upstream credit goes back with every issue
    creditWithIssue: assert property (@(posedge clk) disable iff (rst)
        inCredit == outValid)
        else $error("inCredit and outValid differ");

    // Queue never holds more than its depth
    occupancyBound: assert property (@(posedge clk) disable iff (rst)
        occupancy <= CountWidth'(Depth))
        else $error("queue occupancy above depth");

    // An issue needs a downstream credit one edge earlier
    issueNeedsCredit: assert property (@(posedge clk) disable iff (rst)
        outValid |-> ($past(creditCount) != '0))
        else $error("outValid issued with no downstream credit");

    // Output quiet right after reset
    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !outValid)
        else $error("outValid high in first cycle after reset");

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
// Decode stage top level joining field, control and ALU decoders with the credit queue
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*; #(
    parameter int QueueDepth = 4,
    parameter int OutCredits = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    input  logic [Xlen-1:0]         instruction,
    output logic                    inCredit,
    output logic                    outValid,
    output logic [RegAddrWidth-1:0] rd,
    output logic [RegAddrWidth-1:0] rs1,
    output logic [RegAddrWidth-1:0] rs2,
    output logic [2:0]              func3,
    output logic [Xlen-1:0]         imm,
    output logic                    memWrite,
    output logic                    memRead,
    output logic                    regWrite,
    output logic                    aluSrc,
    output logic                    branch,
    output logic                    memToReg,
    output aluOp_t                  aluOp,
    output aluCtrl_t                aluControl,
    input  logic                    outCredit
);

    // Decoder side
    logic                    decodedValid;
    opcode_t                 opcode;
    logic                    isBase;
    logic                    isArith;
    logic                    isReg;
    logic                    isCondBranch;
    logic [RegAddrWidth-1:0] decRd;
    logic [RegAddrWidth-1:0] decRs1;
    logic [RegAddrWidth-1:0] decRs2;
    logic [2:0]              decFunc3;
    logic [6:0]              decFunc7;
    logic [Xlen-1:0]         decImm;
    logic                    decMemWrite;
    logic                    decMemRead;
    logic                    decRegWrite;
    logic                    decAluSrc;
    logic                    decBranch;
    logic                    decMemToReg;
    aluOp_t                  decAluOp;
    aluCtrl_t                decAluControl;

    // Queue side
    decodedEntry_t writeEntry;
    decodedEntry_t outEntry;

    fieldDecoder fieldDecoder_inst (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .instruction  (instruction),
        .decodedValid (decodedValid),
        .opcode       (opcode),
        .isBase       (isBase),
        .rd           (decRd),
        .rs1          (decRs1),
        .rs2          (decRs2),
        .func3        (decFunc3),
        .func7        (decFunc7),
        .imm          (decImm)
    );

    controlDecoder controlDecoder_inst (
        .opcode   (opcode),
        .isBase   (isBase),
        .memWrite (decMemWrite),
        .memRead  (decMemRead),
        .regWrite (decRegWrite),
        .aluSrc   (decAluSrc),
        .branch   (decBranch),
        .memToReg (decMemToReg),
        .aluOp    (decAluOp),
        .isArith  (isArith)
    );

    // Register form selects SUB and the M extension
    assign isReg = (opcode == OpReg);
    // Jumps also raise branch but still add, so only compares pick SUB
    assign isCondBranch = decBranch && (decAluOp == AluOpBranch);

    aluControlDecoder aluControlDecoder_inst (
        .isArith    (isArith),
        .isReg      (isReg),
        .func3      (decFunc3),
        .func7      (decFunc7),
        .branch     (isCondBranch),
        .memToReg   (decMemToReg),
        .aluControl (decAluControl)
    );

    // Pack decoded word for the queue
    always_comb
    begin
        writeEntry.rd         = decRd;
        writeEntry.rs1        = decRs1;
        writeEntry.rs2        = decRs2;
        writeEntry.func3      = decFunc3;
        writeEntry.imm        = decImm;
        writeEntry.memWrite   = decMemWrite;
        writeEntry.memRead    = decMemRead;
        writeEntry.regWrite   = decRegWrite;
        writeEntry.aluSrc     = decAluSrc;
        writeEntry.branch     = decBranch;
        writeEntry.memToReg   = decMemToReg;
        writeEntry.aluOp      = decAluOp;
        writeEntry.aluControl = decAluControl;
    end

    creditQueue #(
        .Depth   (QueueDepth),
        .Credits (OutCredits)
    ) creditQueue_inst (
        .clk        (clk),
        .rst        (rst),
        .writeValid (decodedValid),
        .writeEntry (writeEntry),
        .outCredit  (outCredit),
        .outValid   (outValid),
        .outEntry   (outEntry),
        .inCredit   (inCredit)
    );

    // Unpack queue head onto the output ports
    assign rd         = outEntry.rd;
    assign rs1        = outEntry.rs1;
    assign rs2        = outEntry.rs2;
    assign func3      = outEntry.func3;
    assign imm        = outEntry.imm;
    assign memWrite   = outEntry.memWrite;
    assign memRead    = outEntry.memRead;
    assign regWrite   = outEntry.regWrite;
    assign aluSrc     = outEntry.aluSrc;
    assign branch     = outEntry.branch;
    assign memToReg   = outEntry.memToReg;
    assign aluOp      = outEntry.aluOp;
    assign aluControl = outEntry.aluControl;

endmodule

`default_nettype wire

//--- logic/creditQueue.sv
// Decoded-entry circular queue with downstream credit counter and upstream credit return
`timescale 1ns/1ps
`default_nettype none

module creditQueue import decodePkg::*; #(
    parameter int Depth   = 4,
    parameter int Credits = 2
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          writeValid,
    input  decodedEntry_t writeEntry,
    input  logic          outCredit,
    output logic          outValid,
    output decodedEntry_t outEntry,
    output logic          inCredit
);

    localparam int PtrWidth    = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth  = $clog2(Depth + 1);
    localparam int CreditWidth = $clog2(Credits + 1);

    decodedEntry_t mem [Depth];

    logic [PtrWidth-1:0]    headPtr;
    logic [PtrWidth-1:0]    tailPtr;
    logic [CountWidth-1:0]  occupancy;
    logic [CreditWidth-1:0] creditCount;
    logic [CreditWidth-1:0] creditNext;
    logic                   issue;

    // Pop whenever an entry waits and downstream has room
    assign issue = (occupancy != '0) && (creditCount != '0);

    // Credit count capped at Credits
    always_comb
    begin
        creditNext = creditCount;
        if (issue && !outCredit)
        begin
            creditNext = creditCount - 1'b1;
        end
        else if (!issue && outCredit && (creditCount != CreditWidth'(Credits)))
        begin
            creditNext = creditCount + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            headPtr     <= '0;
            tailPtr     <= '0;
            occupancy   <= '0;
            creditCount <= CreditWidth'(Credits);
            outValid    <= 1'b0;
            inCredit    <= 1'b0;
        end
        else
        begin
            if (writeValid)
            begin
                tailPtr <= (tailPtr == PtrWidth'(Depth - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (issue)
            begin
                headPtr <= (headPtr == PtrWidth'(Depth - 1)) ? '0 : headPtr + 1'b1;
            end
            // Simultaneous push and pop leave occupancy unchanged
            occupancy   <= occupancy + CountWidth'(writeValid) - CountWidth'(issue);
            creditCount <= creditNext;
            // Freed slot is returned upstream with the issue
            outValid    <= issue;
            inCredit    <= issue;
        end
    end

    // Storage and issue register
    always_ff @(posedge clk)
    begin
        if (writeValid)
        begin
            mem[tailPtr] <= writeEntry;
        end
        if (issue)
        begin
            outEntry <= mem[headPtr];
        end
    end

endmodule

`default_nettype wire

//--- logic/aluControlDecoder.sv
// func3/func7 to exact ALU operation for base arithmetic and M-extension words
`timescale 1ns/1ps
`default_nettype none

module aluControlDecoder import decodePkg::*; (
    input  logic     isArith,
    input  logic     isReg,
    input  logic [2:0] func3,
    input  logic [6:0] func7,
    input  logic     branch,
    input  logic     memToReg,
    output aluCtrl_t aluControl
);

    always_comb
    begin
        aluControl = AluAdd;
        if (!isArith)
        begin
            // Compare for branches and address add for everything else
            aluControl = (branch && !memToReg) ? AluSub : AluAdd;
        end
        else if (isReg && (func7 == FuncMulDiv))
        begin
            // Multiply/divide family
            case (func3)
                3'd0: aluControl = AluMul;
                3'd1: aluControl = AluMulh;
                3'd2: aluControl = AluMulhsu;
                3'd3: aluControl = AluMulhu;
                3'd4: aluControl = AluDiv;
                3'd5: aluControl = AluDivu;
                3'd6: aluControl = AluRem;
                default: aluControl = AluRemu;
            endcase
        end
        else
        begin
            case (func3)
                // SUB only exists in register form
                3'd0: aluControl = (isReg && func7[5]) ? AluSub : AluAdd;
                3'd1: aluControl = AluSll;
                3'd2: aluControl = AluSlt;
                3'd3: aluControl = AluSltu;
                3'd4: aluControl = AluXor;
                // Arithmetic shift flagged by func7 bit 5 in both forms
                3'd5: aluControl = func7[5] ? AluSra : AluSrl;
                3'd6: aluControl = AluOr;
                default: aluControl = AluAnd;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/controlDecoder.sv
// Opcode to datapath control flags and ALU operation class
`timescale 1ns/1ps
`default_nettype none

module controlDecoder import decodePkg::*; (
    input  opcode_t opcode,
    input  logic    isBase,
    output logic    memWrite,
    output logic    memRead,
    output logic    regWrite,
    output logic    aluSrc,
    output logic    branch,
    output logic    memToReg,
    output aluOp_t  aluOp,
    output logic    isArith
);

    always_comb
    begin
        // NOP defaults with immediate path and arith class
        memWrite = 1'b0;
        memRead  = 1'b0;
        regWrite = 1'b0;
        aluSrc   = 1'b1;
        branch   = 1'b0;
        memToReg = 1'b0;
        aluOp    = AluOpArith;

        // Non-base encodings fall through as NOP
        if (isBase)
        begin
            case (opcode)
                OpLui:
                begin
                    regWrite = 1'b1;
                    aluOp    = AluOpUpper;
                end
                OpAuipc:
                begin
                    regWrite = 1'b1;
                    aluOp    = AluOpPc;
                end
                OpJal:
                begin
                    regWrite = 1'b1;
                    branch   = 1'b1;
                    aluOp    = AluOpJump;
                end
                OpJalr:
                begin
                    regWrite = 1'b1;
                    branch   = 1'b1;
                    aluOp    = AluOpJumpReg;
                end
                OpBranch:
                begin
                    // Compare uses both registers
                    aluSrc = 1'b0;
                    branch = 1'b1;
                    aluOp  = AluOpBranch;
                end
                OpLoad:
                begin
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    aluOp    = AluOpMem;
                end
                OpStore:
                begin
                    memWrite = 1'b1;
                    aluOp    = AluOpMem;
                end
                OpImm:
                begin
                    regWrite = 1'b1;
                end
                OpReg:
                begin
                    aluSrc   = 1'b0;
                    regWrite = 1'b1;
                end
                // ECALL, EBREAK and unknown opcodes stay NOP
                default:
                begin
                end
            endcase
        end
    end

    // Arithmetic words need func3/func7 decode downstream
    assign isArith = isBase && ((opcode == OpImm) || (opcode == OpReg));

endmodule

`default_nettype wire

//--- logic/fieldDecoder.sv
// Instruction register, field split and sign-extended immediate generation
`timescale 1ns/1ps
`default_nettype none

module fieldDecoder import decodePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    input  logic [Xlen-1:0]         instruction,
    output logic                    decodedValid,
    output opcode_t                 opcode,
    output logic                    isBase,
    output logic [RegAddrWidth-1:0] rd,
    output logic [RegAddrWidth-1:0] rs1,
    output logic [RegAddrWidth-1:0] rs2,
    output logic [2:0]              func3,
    output logic [6:0]              func7,
    output logic [Xlen-1:0]         imm
);

    logic [Xlen-1:0] instrReg;

    // Valid flag trails the accepted word by one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            decodedValid <= 1'b0;
        end
        else
        begin
            decodedValid <= inValid;
        end
    end

    // Word captured only on an accepted transfer
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            instrReg <= instruction;
        end
    end

    // Fixed field positions
    assign opcode = opcode_t'(instrReg[6:2]);
    assign isBase = (instrReg[1:0] == 2'b11);
    assign rd     = instrReg[11:7];
    assign rs1    = instrReg[19:15];
    assign rs2    = instrReg[24:20];
    assign func3  = instrReg[14:12];
    assign func7  = instrReg[31:25];

    // Immediate by format with bit 31 always the sign
    always_comb
    begin
        imm = '0;
        if (isBase)
        begin
            case (opcode)
                OpLui, OpAuipc: imm = {instrReg[31:12], 12'b0};
                OpJal:          imm = {{12{instrReg[31]}}, instrReg[19:12], instrReg[20],
                                       instrReg[30:21], 1'b0};
                OpBranch:       imm = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                                       instrReg[11:8], 1'b0};
                OpStore:        imm = {{21{instrReg[31]}}, instrReg[30:25], instrReg[11:7]};
                OpJalr, OpLoad, OpImm:
                                imm = {{21{instrReg[31]}}, instrReg[30:20]};
                // R-type, system and unknown words carry no immediate
                default:        imm = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/decodePkg.sv
// Decode stage widths, opcode constants, ALU operation codes and queued entry record
`default_nettype none

package decodePkg;

    // Datapath and register index widths
    localparam int Xlen = 32;
    localparam int RegAddrWidth = 5;

    // Major opcode from instruction bits 6..2
    typedef enum logic [4:0] {
        OpLoad   = 5'b00000,
        OpImm    = 5'b00100,
        OpAuipc  = 5'b00101,
        OpStore  = 5'b01000,
        OpReg    = 5'b01100,
        OpLui    = 5'b01101,
        OpBranch = 5'b11000,
        OpJalr   = 5'b11001,
        OpJal    = 5'b11011,
        OpSystem = 5'b11100
    } opcode_t;

    // Operation class handed to execute
    typedef enum logic [2:0] {
        AluOpMem     = 3'd0,
        AluOpBranch  = 3'd1,
        AluOpArith   = 3'd2,
        AluOpJump    = 3'd3,
        AluOpUpper   = 3'd4,
        AluOpPc      = 3'd5,
        AluOpJumpReg = 3'd7
    } aluOp_t;

    // Exact ALU operation with value 5 unused
    typedef enum logic [4:0] {
        AluAnd    = 5'd0,
        AluOr     = 5'd1,
        AluAdd    = 5'd2,
        AluXor    = 5'd3,
        AluSub    = 5'd4,
        AluSll    = 5'd6,
        AluSrl    = 5'd7,
        AluSra    = 5'd8,
        AluSlt    = 5'd9,
        AluSltu   = 5'd10,
        AluMul    = 5'd11,
        AluMulh   = 5'd12,
        AluMulhsu = 5'd13,
        AluMulhu  = 5'd14,
        AluDiv    = 5'd15,
        AluDivu   = 5'd16,
        AluRem    = 5'd17,
        AluRemu   = 5'd18
    } aluCtrl_t;

    // func7 marking multiply/divide words
    localparam logic [6:0] FuncMulDiv = 7'b0000001;

    // One decoded instruction as held in the output queue
    typedef struct packed {
        logic [RegAddrWidth-1:0] rd;
        logic [RegAddrWidth-1:0] rs1;
        logic [RegAddrWidth-1:0] rs2;
        logic [2:0]              func3;
        logic [Xlen-1:0]         imm;
        logic                    memWrite;
        logic                    memRead;
        logic                    regWrite;
        logic                    aluSrc;
        logic                    branch;
        logic                    memToReg;
        aluOp_t                  aluOp;
        aluCtrl_t                aluControl;
    } decodedEntry_t;

endpackage

`default_nettype wire
